// File: design/sprite_settings.svh
`ifndef SPRITE_SETTINGS_SVH
`define SPRITE_SETTINGS_SVH

// Sprite entries walked on every line
`define SPRITE_COUNT 32

// Sprite width and height in pixels
`define SPRITE_SIZE 16

// Visible pixels on one line
`define LINE_WIDTH 256

// Object RAM depths in bytes
`define ATTR_DEPTH 4096
`define POS_DEPTH 2048

// CPU address bus width
`define APB_ADDR_W 13

`endif

// File: design/sprite_pkg.sv
package sprite_pkg;

	// One object RAM word
	typedef logic [7:0] byte_t;

	// Colour index, 0 is transparent
	typedef logic [3:0] pixel_t;

	// X, y or line number
	typedef logic [7:0] coord_t;

	// Render engine states
	typedef enum logic [2:0] {
		SCAN_IDLE,
		// Back half wiped to transparent
		SCAN_CLEAR,
		// Entry bytes pulled in during scan slots
		SCAN_FETCH,
		// Line range and colour check
		SCAN_TEST,
		SCAN_DRAW,
		// Last cycle with render_busy high
		SCAN_DONE
	} scan_state_t;

endpackage

// File: design/obj_ram_if.sv
`timescale 1ns/1ps

// One synchronous RAM port, clock carried along
interface obj_ram_if #(
	parameter int ADDR_W = 8,
	parameter type payload_t = sprite_pkg::byte_t
) (
	input logic clk_6m
);

	logic cs;
	logic we;
	logic [ADDR_W-1:0] addr;
	payload_t wdata;
	// Valid the cycle after a read select
	payload_t rdata;

	// Side that issues the accesses
	modport ctrl (output cs, we, addr, wdata, input rdata);

	// Array side
	modport mem (input clk_6m, cs, we, addr, wdata, output rdata);

endinterface

// File: design/obj_scan_if.sv
`timescale 1ns/1ps
`include "sprite_settings.svh"

// Scanner reads from both object RAMs in its own slots
interface obj_scan_if;
	import sprite_pkg::*;

	logic scan_slot;
	logic scan_req;
	logic [$clog2(`ATTR_DEPTH)-1:0] attr_addr;
	logic [$clog2(`POS_DEPTH)-1:0] pos_addr;
	// Both bytes land one cycle after the request
	byte_t attr_data;
	byte_t pos_data;

	modport bus (output scan_slot, attr_data, pos_data, input scan_req, attr_addr, pos_addr);

	modport scanner (input scan_slot, attr_data, pos_data, output scan_req, attr_addr, pos_addr);

endinterface

// File: design/obj_ram.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Single-port synchronous RAM
// Object bytes and line-buffer pixels share this block
////////////////////////////////////////////////////////////

module obj_ram #(
	parameter type payload_t = sprite_pkg::byte_t,
	parameter int DEPTH = 256
) (
	obj_ram_if.mem mem
);

	// Storage, contents undefined at power-up
	payload_t array [DEPTH];

	always_ff @(posedge mem.clk_6m) begin
		if (mem.cs) begin
			if (mem.we) begin
				array[mem.addr] <= mem.wdata;
			end else begin
				// Read word held until the next read
				mem.rdata <= array[mem.addr];
			end
		end
	end

endmodule

// File: design/obj_bus_ctrl.sv
`timescale 1ns/1ps
`include "sprite_settings.svh"

////////////////////////////////////////////////////////////
// CPU side of the object RAMs
// APB slave sharing both RAMs with the scanner by slot
////////////////////////////////////////////////////////////

module obj_bus_ctrl (
	input  logic clk_6m,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  sprite_pkg::byte_t pwdata,
	output sprite_pkg::byte_t prdata,
	output logic pready,
	output logic pslverr,
	obj_ram_if.ctrl attr,
	obj_ram_if.ctrl pos,
	obj_scan_if.bus scan
);
	import sprite_pkg::*;

	localparam int ATTR_AW = $clog2(`ATTR_DEPTH);
	localparam int POS_AW = $clog2(`POS_DEPTH);

	// Scanner owns the RAMs while high
	logic scan_slot;
	logic access;
	logic sel_attr;
	logic sel_pos;
	logic addr_err;
	// CPU access issued to a RAM this cycle
	logic cpu_go;
	logic ready_q;
	// Which RAM the pending read came from
	logic rd_attr_q;
	byte_t cpu_rdata;

	// Slot toggle, like the 1H phase
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			scan_slot <= 1'b0;
		end else begin
			scan_slot <= ~scan_slot;
		end
	end

	assign scan.scan_slot = scan_slot;

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	// Bit 12 low is attribute RAM
	assign sel_attr = ~paddr[ATTR_AW];
	// 0x1000 to 0x17FF is position RAM
	assign sel_pos = paddr[ATTR_AW] & ~paddr[POS_AW];
	// 0x1800 to 0x1FFF hits nothing
	assign addr_err = paddr[ATTR_AW] & paddr[POS_AW];

	assign access = psel & penable;

	// First CPU slot of the access phase
	assign cpu_go = access & ~addr_err & ~scan_slot;

	////////////////////////////////////////////////////////////
	// RAM multiplexing
	////////////////////////////////////////////////////////////

	always_comb begin
		// Scanner only ever reads
		if (scan_slot) begin
			attr.cs = scan.scan_req;
			attr.we = 1'b0;
			attr.addr = scan.attr_addr;
			pos.cs = scan.scan_req;
			pos.we = 1'b0;
			pos.addr = scan.pos_addr;
		end else begin
			attr.cs = cpu_go & sel_attr;
			attr.we = pwrite;
			attr.addr = paddr[ATTR_AW-1:0];
			pos.cs = cpu_go & sel_pos;
			pos.we = pwrite;
			pos.addr = paddr[POS_AW-1:0];
		end
		attr.wdata = pwdata;
		pos.wdata = pwdata;
	end

	// Scanner data straight off the RAM registers
	assign scan.attr_data = attr.rdata;
	assign scan.pos_data = pos.rdata;

	////////////////////////////////////////////////////////////
	// APB completion
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= 1'b0;
			rd_attr_q <= 1'b0;
		end else begin
			ready_q <= cpu_go;
			if (cpu_go) begin
				rd_attr_q <= sel_attr;
			end
		end
	end

	assign cpu_rdata = rd_attr_q ? attr.rdata : pos.rdata;

	// Error ends in the first access cycle
	assign pready = ready_q | (access & addr_err);
	assign pslverr = access & addr_err;
	// Zero outside a RAM completion
	assign prdata = ready_q ? cpu_rdata : '0;

endmodule

// File: design/sprite_scanner.sv
`timescale 1ns/1ps
`include "sprite_settings.svh"

////////////////////////////////////////////////////////////
// Per-line render engine
// Clear, then fetch, test and draw each entry in turn
////////////////////////////////////////////////////////////

module sprite_scanner (
	input  logic clk_6m,
	input  logic rst_n,
	input  logic line_start,
	input  sprite_pkg::coord_t line_num,
	output logic render_busy,
	output logic swap,
	obj_scan_if.scanner scan,
	output logic wr_en,
	output sprite_pkg::coord_t wr_x,
	output sprite_pkg::pixel_t wr_pixel
);
	import sprite_pkg::*;

	localparam int ATTR_AW = $clog2(`ATTR_DEPTH);
	localparam int POS_AW = $clog2(`POS_DEPTH);
	localparam int IDX_W = $clog2(`SPRITE_COUNT);
	localparam int DCNT_W = $clog2(`SPRITE_SIZE);
	localparam coord_t LAST_COL = coord_t'(`LINE_WIDTH - 1);

	scan_state_t state;
	logic [IDX_W-1:0] idx;
	// Even steps request, odd steps capture
	logic [1:0] fstep;
	// Column for clear and draw
	coord_t col;
	logic [DCNT_W-1:0] dcnt;
	coord_t line_q;
	coord_t x_q;
	coord_t y_q;
	pixel_t colour_q;
	coord_t dy;
	logic hit;
	logic draw_end;
	logic last_idx;
	// Move on to the next entry
	logic advance;

	////////////////////////////////////////////////////////////
	// Line range test
	////////////////////////////////////////////////////////////

	// No wraparound, line must not be above y
	assign dy = line_q - y_q;
	assign hit = (line_q >= y_q) && (dy < coord_t'(`SPRITE_SIZE)) && (colour_q != '0);

	// Sprite width done or right edge reached
	assign draw_end = (dcnt == DCNT_W'(`SPRITE_SIZE - 1)) || (col == LAST_COL);
	assign last_idx = (idx == IDX_W'(`SPRITE_COUNT - 1));

	assign advance = ((state == SCAN_TEST) && !hit) || ((state == SCAN_DRAW) && draw_end);

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			state <= SCAN_IDLE;
			idx <= '0;
			fstep <= '0;
			col <= '0;
			dcnt <= '0;
		end else begin
			case (state)
				SCAN_IDLE: begin
					if (line_start) begin
						col <= '0;
						state <= SCAN_CLEAR;
					end
				end
				SCAN_CLEAR: begin
					col <= col + 1'b1;
					if (col == LAST_COL) begin
						idx <= '0;
						fstep <= '0;
						state <= SCAN_FETCH;
					end
				end
				SCAN_FETCH: begin
					// Requests wait for a scanner slot
					if (!fstep[0]) begin
						if (scan.scan_slot) begin
							fstep <= fstep + 2'd1;
						end
					end else if (!fstep[1]) begin
						fstep <= 2'd2;
					end else begin
						state <= SCAN_TEST;
					end
				end
				SCAN_TEST: begin
					if (hit) begin
						col <= x_q;
						dcnt <= '0;
						state <= SCAN_DRAW;
					end
				end
				SCAN_DRAW: begin
					col <= col + 1'b1;
					dcnt <= dcnt + 1'b1;
				end
				SCAN_DONE: state <= SCAN_IDLE;
				default: state <= SCAN_IDLE;
			endcase

			// Entry finished, skipped or drawn
			if (advance) begin
				if (last_idx) begin
					state <= SCAN_DONE;
				end else begin
					idx <= idx + 1'b1;
					fstep <= '0;
					state <= SCAN_FETCH;
				end
			end
		end
	end

	// Latched entry and line values
	always_ff @(posedge clk_6m) begin
		if (state == SCAN_IDLE && line_start) begin
			line_q <= line_num;
		end
		if (state == SCAN_FETCH && fstep == 2'd1) begin
			x_q <= scan.attr_data;
			y_q <= scan.pos_data;
		end
		if (state == SCAN_FETCH && fstep == 2'd3) begin
			colour_q <= scan.attr_data[3:0];
		end
	end

	// Bytes 4i and 2i first, then byte 4i+1
	assign scan.scan_req = (state == SCAN_FETCH) && !fstep[0] && scan.scan_slot;
	assign scan.attr_addr = ATTR_AW'({idx, 1'b0, fstep[1]});
	assign scan.pos_addr = POS_AW'({idx, 1'b0});

	// Swap on the accepted pulse only
	assign swap = (state == SCAN_IDLE) && line_start;
	assign render_busy = (state != SCAN_IDLE);

	assign wr_en = (state == SCAN_CLEAR) || (state == SCAN_DRAW);
	assign wr_x = col;
	assign wr_pixel = (state == SCAN_DRAW) ? colour_q : '0;

endmodule

// File: design/sprite_line_buffer.sv
`timescale 1ns/1ps
`include "sprite_settings.svh"

////////////////////////////////////////////////////////////
// Double line buffer
// Scanner fills the back half, display reads the front
////////////////////////////////////////////////////////////

module sprite_line_buffer (
	input  logic clk_6m,
	input  logic rst_n,
	input  logic swap,
	input  logic wr_en,
	input  sprite_pkg::coord_t wr_x,
	input  sprite_pkg::pixel_t wr_pixel,
	input  sprite_pkg::coord_t pix_x,
	output sprite_pkg::pixel_t pix_color
);
	import sprite_pkg::*;

	localparam int BUF_AW = $clog2(`LINE_WIDTH);

	// High when half 1 is the front
	logic front_sel;
	// Set by the first swap
	logic front_valid;
	// Aligned with the registered read
	logic rd_sel_q;
	logic rd_valid_q;

	obj_ram_if #(.ADDR_W(BUF_AW), .payload_t(pixel_t)) half0_if (.clk_6m(clk_6m));
	obj_ram_if #(.ADDR_W(BUF_AW), .payload_t(pixel_t)) half1_if (.clk_6m(clk_6m));

	obj_ram #(.payload_t(pixel_t), .DEPTH(`LINE_WIDTH)) half0_ram_i (.mem(half0_if.mem));
	obj_ram #(.payload_t(pixel_t), .DEPTH(`LINE_WIDTH)) half1_ram_i (.mem(half1_if.mem));

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			front_sel <= 1'b0;
			front_valid <= 1'b0;
			rd_sel_q <= 1'b0;
			rd_valid_q <= 1'b0;
		end else begin
			if (swap) begin
				front_sel <= ~front_sel;
				front_valid <= 1'b1;
			end
			rd_sel_q <= front_sel;
			rd_valid_q <= front_valid;
		end
	end

	// Back half written, front half read every cycle
	assign half0_if.cs = front_sel ? wr_en : 1'b1;
	assign half0_if.we = front_sel;
	assign half0_if.addr = front_sel ? wr_x : pix_x;
	assign half0_if.wdata = wr_pixel;

	assign half1_if.cs = front_sel ? 1'b1 : wr_en;
	assign half1_if.we = ~front_sel;
	assign half1_if.addr = front_sel ? pix_x : wr_x;
	assign half1_if.wdata = wr_pixel;

	// Transparent until a front half exists
	assign pix_color = rd_valid_q ? (rd_sel_q ? half1_if.rdata : half0_if.rdata) : '0;

endmodule

// File: design/sprite_subsystem.sv
`timescale 1ns/1ps
`include "sprite_settings.svh"

////////////////////////////////////////////////////////////
// Object subsystem top level
////////////////////////////////////////////////////////////

module sprite_subsystem (
	input  logic clk_6m,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  sprite_pkg::byte_t pwdata,
	output sprite_pkg::byte_t prdata,
	output logic pready,
	output logic pslverr,
	input  logic line_start,
	input  sprite_pkg::coord_t line_num,
	output logic render_busy,
	input  sprite_pkg::coord_t pix_x,
	output sprite_pkg::pixel_t pix_color
);
	import sprite_pkg::*;

	localparam int ATTR_AW = $clog2(`ATTR_DEPTH);
	localparam int POS_AW = $clog2(`POS_DEPTH);

	// Scanner to line buffer
	logic swap;
	logic wr_en;
	coord_t wr_x;
	pixel_t wr_pixel;

	obj_ram_if #(.ADDR_W(ATTR_AW), .payload_t(byte_t)) attr_if (.clk_6m(clk_6m));
	obj_ram_if #(.ADDR_W(POS_AW), .payload_t(byte_t)) pos_if (.clk_6m(clk_6m));
	obj_scan_if scan_if ();

	obj_bus_ctrl bus_ctrl_i (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.attr(attr_if.ctrl),
		.pos(pos_if.ctrl),
		.scan(scan_if.bus)
	);

	// Attribute bytes, x and colour
	obj_ram #(.payload_t(byte_t), .DEPTH(`ATTR_DEPTH)) attr_ram_i (.mem(attr_if.mem));
	// Position bytes, y
	obj_ram #(.payload_t(byte_t), .DEPTH(`POS_DEPTH)) pos_ram_i (.mem(pos_if.mem));

	sprite_scanner scanner_i (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.line_start(line_start),
		.line_num(line_num),
		.render_busy(render_busy),
		.swap(swap),
		.scan(scan_if.scanner),
		.wr_en(wr_en),
		.wr_x(wr_x),
		.wr_pixel(wr_pixel)
	);

	sprite_line_buffer line_buffer_i (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.swap(swap),
		.wr_en(wr_en),
		.wr_x(wr_x),
		.wr_pixel(wr_pixel),
		.pix_x(pix_x),
		.pix_color(pix_color)
	);

endmodule

// File: tb/sprite_subsystem_assert.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// APB and line control protocol checks
////////////////////////////////////////////////////////////

module sprite_subsystem_assert (
	input logic clk_6m,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic line_start,
	input logic render_busy
);

	// Access cycles so far without pready
	logic [1:0] wait_cnt;
	// One sticky flag per check
	logic err_slverr = 1'b0;
	logic err_ready = 1'b0;
	logic err_wait = 1'b0;
	logic err_rise = 1'b0;
	logic err_accept = 1'b0;
	logic fail_seen;

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
		end else if (psel && penable && !pready) begin
			wait_cnt <= wait_cnt + 2'd1;
		end else begin
			wait_cnt <= '0;
		end
	end

	assign fail_seen = err_slverr | err_ready | err_wait | err_rise | err_accept;

	// Error response only on a completing cycle
	slverr_with_ready: assert property (@(posedge clk_6m) disable iff (!rst_n)
		pslverr |-> pready)
	else begin
		$error("pslverr high without pready");
		err_slverr = 1'b1;
	end

	ready_in_access: assert property (@(posedge clk_6m) disable iff (!rst_n)
		pready |-> (psel && penable))
	else begin
		$error("pready high outside an access phase");
		err_ready = 1'b1;
	end

	// At most 3 access cycles
	ready_in_time: assert property (@(posedge clk_6m) disable iff (!rst_n)
		(psel && penable && !pready) |-> (wait_cnt < 2'd2))
	else begin
		$error("pready missing on the third access cycle");
		err_wait = 1'b1;
	end

	busy_after_start: assert property (@(posedge clk_6m) disable iff (!rst_n)
		$rose(render_busy) |-> $past(line_start))
	else begin
		$error("render_busy rose without line_start");
		err_rise = 1'b1;
	end

	// Idle scanner takes every pulse
	start_accepted: assert property (@(posedge clk_6m) disable iff (!rst_n)
		(line_start && !render_busy) |=> render_busy)
	else begin
		$error("line_start while idle left render_busy low");
		err_accept = 1'b1;
	end

endmodule

bind sprite_subsystem sprite_subsystem_assert protocol_assert_i (
	.clk_6m(clk_6m),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.line_start(line_start),
	.render_busy(render_busy)
);

// File: tb/sprite_subsystem_tb.sv
`timescale 1ns/1ps
`include "sprite_settings.svh"

module sprite_subsystem_tb;
	import sprite_pkg::*;

	typedef logic [`APB_ADDR_W-1:0] apb_addr_t;

	localparam int APB_TIMEOUT = 8;
	localparam int RENDER_TIMEOUT = 4000;
	// Rounds of CPU traffic allowed in one render
	localparam int TRAFFIC_LIMIT = 100;
	// Covered by the random sprites
	localparam int L_MAIN = 100;
	// Below every sprite
	localparam int L_EMPTY = 200;

	logic clk_6m;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	byte_t pwdata;
	byte_t prdata;
	logic pready;
	logic pslverr;
	logic line_start;
	coord_t line_num;
	logic render_busy;
	coord_t pix_x;
	pixel_t pix_color;

	// Mirror of both object RAMs
	byte_t attr_m [`ATTR_DEPTH];
	byte_t pos_m [`POS_DEPTH];
	apb_addr_t addr_q [$];
	int seed;
	int n;
	int a;
	int x;
	int y;
	byte_t rd;
	logic err;

	sprite_subsystem sprite_subsystem_i (.*);

	initial begin
		clk_6m = 1'b0;
		forever #4 clk_6m = ~clk_6m;
	end

	////////////////////////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////////////////////////

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic show_mismatch(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("MISMATCH %s expected 0x%0h actual 0x%0h", test, expected, actual);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// Bound checker flags a failed protocol property
	always @(negedge clk_6m) begin
		if (sprite_subsystem_i.protocol_assert_i.fail_seen) begin
			stop_with_error("a concurrent protocol assertion failed");
		end
	end

	////////////////////////////////////////////////////////////
	// APB master and reference model
	////////////////////////////////////////////////////////////

	// Setup phase and then access until pready
	task automatic apb_access(input logic wr, input apb_addr_t addr, input byte_t wdata,
			output byte_t rdata, output logic slverr);
		int cycles;
		@(negedge clk_6m);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge clk_6m);
		penable = 1'b1;
		cycles = 0;
		do begin
			@(negedge clk_6m);
			cycles++;
			if (cycles > APB_TIMEOUT) begin
				stop_with_error($sformatf("APB access to 0x%0h got no pready", addr));
			end
		end while (!pready);
		rdata = prdata;
		slverr = pslverr;
		// Held through the completing edge
		@(negedge clk_6m);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// Bit 12 picks the RAM and bit 11 marks the hole
	function automatic byte_t expected_byte(input apb_addr_t addr);
		return !addr[12] ? attr_m[addr[11:0]] : pos_m[addr[10:0]];
	endfunction

	task automatic write_byte(input apb_addr_t addr, input byte_t data);
		byte_t unused;
		logic slverr;
		apb_access(1'b1, addr, data, unused, slverr);
		assert (!slverr) else show_mismatch("write pslverr", 0, slverr);
		if (!addr[12]) begin
			attr_m[addr[11:0]] = data;
		end else if (!addr[11]) begin
			pos_m[addr[10:0]] = data;
		end
	endtask

	task automatic read_and_compare(input string test, input apb_addr_t addr);
		byte_t data;
		logic slverr;
		apb_access(1'b0, addr, 8'h00, data, slverr);
		assert (!slverr) else show_mismatch({test, " pslverr"}, 0, slverr);
		assert (data == expected_byte(addr))
		else show_mismatch(test, expected_byte(addr), data);
	endtask

	// Highest covering index wins
	function automatic pixel_t expected_pixel(input int line, input int col);
		pixel_t c;
		int i;
		int sx;
		int sy;
		c = '0;
		for (i = 0; i < `SPRITE_COUNT; i++) begin
			sx = attr_m[4*i];
			sy = pos_m[2*i];
			if (attr_m[4*i+1][3:0] != 4'h0 && line >= sy && line < sy + `SPRITE_SIZE
					&& col >= sx && col < sx + `SPRITE_SIZE) begin
				c = attr_m[4*i+1][3:0];
			end
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////
	// Line control and display sweep
	////////////////////////////////////////////////////////////

	task automatic start_line(input int line);
		@(negedge clk_6m);
		assert (!render_busy) else stop_with_error("render still busy before line_start");
		line_start = 1'b1;
		line_num = coord_t'(line);
		@(negedge clk_6m);
		line_start = 1'b0;
		assert (render_busy) else show_mismatch("render_busy after line_start", 1, render_busy);
	endtask

	task automatic wait_render_done();
		int cycles;
		cycles = 0;
		while (render_busy) begin
			@(negedge clk_6m);
			cycles++;
			if (cycles > RENDER_TIMEOUT) begin
				stop_with_error("render_busy did not fall before the timeout");
			end
		end
	endtask

	// Colour shows one cycle after pix_x
	task automatic sweep_line(input string test, input int line);
		int col;
		for (col = 0; col < `LINE_WIDTH; col++) begin
			@(negedge clk_6m);
			pix_x = coord_t'(col);
			@(negedge clk_6m);
			assert (pix_color == expected_pixel(line, col))
			else show_mismatch($sformatf("%s col %0d", test, col),
				expected_pixel(line, col), pix_color);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		line_start = 1'b0;
		line_num = '0;
		pix_x = '0;
		seed = 31515;
		repeat (8) @(posedge clk_6m);
		@(negedge clk_6m);
		rst_n = 1'b1;
		@(negedge clk_6m);

		// Outputs quiet after reset
		assert (!pready) else show_mismatch("reset pready", 0, pready);
		assert (!pslverr) else show_mismatch("reset pslverr", 0, pslverr);
		assert (!render_busy) else show_mismatch("reset render_busy", 0, render_busy);
		assert (pix_color == 4'h0) else show_mismatch("reset pix_color", 0, pix_color);

		// Random bytes in both RAMs
		for (n = 0; n < 12; n++) begin
			a = $random(seed);
			addr_q.push_back(apb_addr_t'(a & 32'hFFF));
			addr_q.push_back(apb_addr_t'(32'h1000 | ((a >> 12) & 32'h7FF)));
		end
		foreach (addr_q[k]) write_byte(addr_q[k], byte_t'($random(seed)));
		foreach (addr_q[k]) read_and_compare("random readback", addr_q[k]);

		// Hole at 0x1800 leaves both aliases untouched
		write_byte(13'h08A5, 8'h3C);
		write_byte(13'h10A5, 8'h5A);
		apb_access(1'b1, 13'h18A5, 8'hC3, rd, err);
		assert (err) else show_mismatch("error write pslverr", 1, err);
		assert (rd == 8'h00) else show_mismatch("error write prdata", 0, rd);
		apb_access(1'b0, 13'h1FFF, 8'h00, rd, err);
		assert (err) else show_mismatch("error read pslverr", 1, err);
		assert (rd == 8'h00) else show_mismatch("error read prdata", 0, rd);
		read_and_compare("alias attr", 13'h08A5);
		read_and_compare("alias pos", 13'h10A5);

		// Sprite table with every eighth one at the right edge
		for (n = 0; n < `SPRITE_COUNT; n++) begin
			a = $random(seed);
			x = (n % 8 == 7) ? 240 + (a & 15) : (a & 255);
			// Edge sprites always cross the main line
			y = (n % 8 == 7) ? L_MAIN - ((a >> 16) & 15)
				: L_MAIN - 20 + ((a >> 16) & 31);
			write_byte(apb_addr_t'(4*n), byte_t'(x));
			write_byte(apb_addr_t'(4*n + 1), (n == 10) ? 8'hF0 : byte_t'(a >> 8));
			write_byte(apb_addr_t'(32'h1000 + 2*n), byte_t'(y));
		end

		// Render and then swap it to the front
		start_line(L_MAIN);
		wait_render_done();
		start_line(L_EMPTY);
		sweep_line("rendered line", L_MAIN);
		wait_render_done();

		// Empty line lands in the half that held L_MAIN
		start_line(L_EMPTY);
		wait_render_done();

		// CPU traffic against the sprite fetches in reserved bytes only
		start_line(L_MAIN);
		// Clear phase keeps off the object RAMs
		repeat (`LINE_WIDTH) @(negedge clk_6m);
		assert (render_busy)
		else stop_with_error("render ended before the sprite fetches");
		n = 0;
		while (render_busy) begin
			n++;
			if (n > TRAFFIC_LIMIT) begin
				stop_with_error("render never ended during APB traffic");
			end
			a = $random(seed);
			write_byte(apb_addr_t'(((a & 31) << 2) | 2 | ((a >> 5) & 1)), byte_t'(a >> 8));
			write_byte(apb_addr_t'(32'h1000 | ((a & 31) << 1) | 1), byte_t'(a >> 16));
			read_and_compare("read during render",
				apb_addr_t'((((a >> 20) & 31) << 2) | ((a >> 25) & 1)));
		end
		sweep_line("cleared line", L_EMPTY);
		wait_render_done();
		start_line(L_EMPTY);
		sweep_line("line after traffic", L_MAIN);
		wait_render_done();

		if (sprite_subsystem_i.protocol_assert_i.fail_seen) begin
			stop_with_error("a concurrent protocol assertion failed");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: sprite_subsystem.f
+incdir+design
design/sprite_pkg.sv
design/obj_ram_if.sv
design/obj_scan_if.sv
design/obj_ram.sv
design/obj_bus_ctrl.sv
design/sprite_scanner.sv
design/sprite_line_buffer.sv
design/sprite_subsystem.sv
tb/sprite_subsystem_assert.sv
tb/sprite_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sprite subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module sprite_subsystem_tb \
	-f sprite_subsystem.f \
	-o sprite_sim

# Log decides the result
./obj_dir/sprite_sim +verilator+error+limit+100 2>&1 | tee "$LOG"

if grep -qx "Test OK" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
